// ==== decodeBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decodeBus import mipsExecPkg::*; ();

	// Operation and operand selection
	aluOp_t op;
	regIdx_t rsIdx;
	regIdx_t rtIdx;
	regIdx_t destIdx;
	// Already extended to a full word
	word_t imm;
	// srcB from imm instead of rt
	logic useImm;
	logic writeEn;
	logic illegal;

	// Decoder drives every field
	modport decoder (
		output op,
		output rsIdx,
		output rtIdx,
		output destIdx,
		output imm,
		output useImm,
		output writeEn,
		output illegal
	);

	// Controller side, register indices go straight to the register file
	modport control (
		input op,
		input destIdx,
		input imm,
		input useImm,
		input writeEn,
		input illegal
	);

endinterface

`default_nettype wire

// ==== execControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module execControl import mipsExecPkg::*; (
	input logic clk,
	input logic arstN,
	input logic instrReq,
	input word_t instrIn,
	output logic instrAck,
	output instrWord_t latchedInstr,
	decodeBus.control bus,
	input word_t rdDataA,
	input word_t rdDataB,
	output aluOp_t aluOp,
	output word_t aluA,
	output word_t aluB,
	output logic [4:0] aluShamt,
	input word_t aluResult,
	input logic aluOverflow,
	output logic wrEn,
	output regIdx_t wrIdx,
	output word_t wrData,
	output word_t resultOut,
	output logic resultOverflow,
	output logic resultIllegal
);

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stExec = 2'd1;
	localparam logic [1:0] stAck = 2'd2;

	logic [1:0] state;

	////////////////////
	// Operand routing
	////////////////////
	assign aluOp = bus.op;
	assign aluA = rdDataA;
	assign aluB = bus.useImm ? bus.imm : rdDataB;
	assign aluShamt = latchedInstr.r.shamt;

	// Write back only in execute, skip faults and register zero
	assign wrEn = (state == stExec) && bus.writeEn && !bus.illegal && !aluOverflow
		&& (bus.destIdx != '0);
	assign wrIdx = bus.destIdx;
	assign wrData = aluResult;

	assign instrAck = (state == stAck);

	// Instruction word held for the whole transaction
	always_ff @(posedge clk)
	begin
		if (state == stIdle && instrReq)
		begin
			latchedInstr <= instrIn;
		end
	end

	////////////////////
	// Handshake FSM
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			resultOut <= '0;
			resultOverflow <= 1'b0;
			resultIllegal <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (instrReq)
					begin
						state <= stExec;
					end
				end
				stExec:
				begin
					// Capture result, ack follows
					resultOut <= bus.illegal ? '0 : aluResult;
					resultOverflow <= aluOverflow && !bus.illegal;
					resultIllegal <= bus.illegal;
					state <= stAck;
				end
				stAck:
				begin
					// Hold until the master lets go
					if (!instrReq)
					begin
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Ack only answers a request held across the whole execute step
	assert property (@(posedge clk) disable iff (!arstN)
		$rose(instrAck) |-> (instrReq && $past(instrReq)))
	else $error("instrAck rose without a pending request");

	// Result held steady for the whole acknowledge phase
	assert property (@(posedge clk) disable iff (!arstN)
		(instrAck && $past(instrAck)) |-> $stable(resultOut))
	else $error("resultOut changed while acknowledged");

endmodule

`default_nettype wire

// ==== files.f ====
mipsExecPkg.sv
decodeBus.sv
instrDecoder.sv
regFile.sv
mipsAlu.sv
execControl.sv
mipsExecTop.sv
tbMipsExec.sv

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import mipsExecPkg::*; (
	input instrWord_t instr,
	decodeBus.decoder bus
);

	always_comb
	begin
		// Defaults for R-type
		bus.op = opAddu;
		bus.rsIdx = instr.r.rs;
		bus.rtIdx = instr.r.rt;
		bus.destIdx = instr.r.rd;
		bus.imm = '0;
		bus.useImm = 1'b0;
		bus.writeEn = 1'b1;
		bus.illegal = 1'b0;

		case (instr.r.opcode)
			opcodeSpecial:
			begin
				case (instr.r.funct)
					functAdd: bus.op = opAdd;
					functAddu: bus.op = opAddu;
					functSub: bus.op = opSub;
					functSubu: bus.op = opSubu;
					functAnd: bus.op = opAnd;
					functOr: bus.op = opOr;
					functXor: bus.op = opXor;
					functNor: bus.op = opNor;
					functSlt: bus.op = opSlt;
					functSltu: bus.op = opSltu;
					functSll: bus.op = opSll;
					functSrl: bus.op = opSrl;
					functSra: bus.op = opSra;
					functSllv: bus.op = opSllv;
					functSrlv: bus.op = opSrlv;
					functSrav: bus.op = opSrav;
					default:
					begin
						// Unknown funct
						bus.illegal = 1'b1;
						bus.writeEn = 1'b0;
					end
				endcase
			end
			opcodeAddiu:
			begin
				// Sign-extended immediate, no overflow trap
				bus.op = opAddu;
				bus.imm = {{16{instr.i.imm[15]}}, instr.i.imm};
				bus.useImm = 1'b1;
				bus.destIdx = instr.i.rt;
			end
			opcodeOri:
			begin
				bus.op = opOr;
				bus.imm = {16'h0000, instr.i.imm};
				bus.useImm = 1'b1;
				bus.destIdx = instr.i.rt;
			end
			opcodeLui:
			begin
				// ALU moves the low half up
				bus.op = opLui;
				bus.imm = {16'h0000, instr.i.imm};
				bus.useImm = 1'b1;
				bus.destIdx = instr.i.rt;
			end
			default:
			begin
				// Unsupported opcode
				bus.illegal = 1'b1;
				bus.writeEn = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== mipsAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsAlu import mipsExecPkg::*; (
	input aluOp_t op,
	input word_t srcA,
	input word_t srcB,
	input logic [4:0] shamt,
	output word_t result,
	output logic overflow
);

	word_t sum;
	word_t diff;
	logic lessSigned;
	logic lessUnsigned;
	logic addOvf;
	logic subOvf;

	////////////////////
	// Shared arithmetic
	////////////////////
	assign sum = srcA + srcB;
	assign diff = srcA - srcB;

	// SLT signed, SLTU plain magnitude
	assign lessSigned = $signed(srcA) < $signed(srcB);
	assign lessUnsigned = srcA < srcB;

	// Same-sign operands, result sign flipped
	assign addOvf = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);
	// Opposite-sign operands, result takes sign of srcB
	assign subOvf = (srcA[31] != srcB[31]) && (diff[31] != srcA[31]);

	// Only the trapping forms report it
	assign overflow = ((op == opAdd) && addOvf) || ((op == opSub) && subOvf);

	////////////////////
	// Result mux
	////////////////////
	always_comb
	begin
		case (op)
			opAdd, opAddu: result = sum;
			opSub, opSubu: result = diff;
			opAnd: result = srcA & srcB;
			opOr: result = srcA | srcB;
			opXor: result = srcA ^ srcB;
			opNor: result = ~(srcA | srcB);
			opSlt: result = {31'd0, lessSigned};
			opSltu: result = {31'd0, lessUnsigned};
			// Fixed shifts, amount from shamt
			opSll: result = srcB << shamt;
			opSrl: result = srcB >> shamt;
			opSra: result = $signed(srcB) >>> shamt;
			// Variable shifts, amount from rs low bits
			opSllv: result = srcB << srcA[4:0];
			opSrlv: result = srcB >> srcA[4:0];
			opSrav: result = $signed(srcB) >>> srcA[4:0];
			// Immediate into upper half
			opLui: result = {srcB[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== mipsExecPkg.sv ====
`default_nettype none

package mipsExecPkg;

	////////////////////
	// Architectural sizes
	////////////////////
	localparam int wordWidth = 32;
	localparam int regIdxWidth = 5;
	localparam int numRegs = 32;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;

	// Register-format view of an instruction
	typedef struct packed {
		logic [5:0] opcode;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	// Immediate-format view, same 32 bits
	typedef struct packed {
		logic [5:0] opcode;
		regIdx_t rs;
		regIdx_t rt;
		logic [15:0] imm;
	} iType_t;

	typedef union packed {
		rType_t r;
		iType_t i;
	} instrWord_t;

	// Operations understood by the ALU
	typedef enum logic [4:0] {
		opAdd, opAddu, opSub, opSubu,
		opAnd, opOr, opXor, opNor,
		opSlt, opSltu,
		opSll, opSrl, opSra,
		opSllv, opSrlv, opSrav,
		opLui
	} aluOp_t;

	////////////////////
	// Opcodes
	////////////////////
	localparam logic [5:0] opcodeSpecial = 6'b000000;
	localparam logic [5:0] opcodeAddiu = 6'b001001;
	localparam logic [5:0] opcodeOri = 6'b001101;
	localparam logic [5:0] opcodeLui = 6'b001111;

	// SPECIAL funct codes, arithmetic and logic
	localparam logic [5:0] functAdd = 6'b100000;
	localparam logic [5:0] functAddu = 6'b100001;
	localparam logic [5:0] functSub = 6'b100010;
	localparam logic [5:0] functSubu = 6'b100011;
	localparam logic [5:0] functAnd = 6'b100100;
	localparam logic [5:0] functOr = 6'b100101;
	localparam logic [5:0] functXor = 6'b100110;
	localparam logic [5:0] functNor = 6'b100111;
	localparam logic [5:0] functSlt = 6'b101010;
	localparam logic [5:0] functSltu = 6'b101011;
	// Fixed shifts
	localparam logic [5:0] functSll = 6'b000000;
	localparam logic [5:0] functSrl = 6'b000010;
	localparam logic [5:0] functSra = 6'b000011;
	// Variable shifts
	localparam logic [5:0] functSllv = 6'b000100;
	localparam logic [5:0] functSrlv = 6'b000110;
	localparam logic [5:0] functSrav = 6'b000111;

endpackage

`default_nettype wire

// ==== mipsExecTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsExecTop import mipsExecPkg::*; (
	input logic clk,
	input logic arstN,
	input logic instrReq,
	input word_t instrIn,
	output logic instrAck,
	output word_t resultOut,
	output logic resultOverflow,
	output logic resultIllegal
);

	instrWord_t latchedInstr;
	word_t rdDataA;
	word_t rdDataB;
	aluOp_t aluOp;
	word_t aluA;
	word_t aluB;
	logic [4:0] aluShamt;
	word_t aluResult;
	logic aluOverflow;
	logic wrEn;
	regIdx_t wrIdx;
	word_t wrData;

	// Decoded fields, decoder to controller
	decodeBus decBus ();

	////////////////////
	// Datapath
	////////////////////
	instrDecoder decoderInst (
		.instr (latchedInstr),
		.bus (decBus.decoder)
	);

	// Read indices taken straight off the decode bus
	regFile regFileInst (
		.clk (clk),
		.arstN (arstN),
		.rdIdxA (decBus.rsIdx),
		.rdIdxB (decBus.rtIdx),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn (wrEn),
		.wrIdx (wrIdx),
		.wrData (wrData)
	);

	mipsAlu aluInst (
		.op (aluOp),
		.srcA (aluA),
		.srcB (aluB),
		.shamt (aluShamt),
		.result (aluResult),
		.overflow (aluOverflow)
	);

	////////////////////
	// Control
	////////////////////
	execControl controlInst (
		.clk (clk),
		.arstN (arstN),
		.instrReq (instrReq),
		.instrIn (instrIn),
		.instrAck (instrAck),
		.latchedInstr (latchedInstr),
		.bus (decBus.control),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.aluOp (aluOp),
		.aluA (aluA),
		.aluB (aluB),
		.aluShamt (aluShamt),
		.aluResult (aluResult),
		.aluOverflow (aluOverflow),
		.wrEn (wrEn),
		.wrIdx (wrIdx),
		.wrData (wrData),
		.resultOut (resultOut),
		.resultOverflow (resultOverflow),
		.resultIllegal (resultIllegal)
	);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsExecPkg::*; (
	input logic clk,
	input logic arstN,
	input regIdx_t rdIdxA,
	input regIdx_t rdIdxB,
	output word_t rdDataA,
	output word_t rdDataB,
	input logic wrEn,
	input regIdx_t wrIdx,
	input word_t wrData
);

	// Register zero has no storage
	word_t regs [1:numRegs-1];

	////////////////////
	// Write port
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 1; i < numRegs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn && wrIdx != '0)
		begin
			regs[wrIdx] <= wrData;
		end
	end

	////////////////////
	// Read ports
	////////////////////
	// Index zero reads as constant zero
	assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
	assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

	// Written data reads back next cycle, register zero still reads zero
	property writeReadsBack;
		@(posedge clk) disable iff (!arstN)
		wrEn |=>
			((rdIdxA != $past(wrIdx)
				|| rdDataA == (($past(wrIdx) == '0) ? '0 : $past(wrData)))
			&& (rdIdxB != $past(wrIdx)
				|| rdDataB == (($past(wrIdx) == '0) ? '0 : $past(wrData))));
	endproperty

	assert property (writeReadsBack)
	else $error("register read did not return the value written to it");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert -f files.f --top-module tbMipsExec -o simv; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/simv > "$logFile" 2>&1; then
	cat "$logFile"
	echo "Simulation exited with an error status"
	exit 1
fi

cat "$logFile"

if grep -q "^TB PASSED$" "$logFile"; then
	exit 0
else
	echo "Pass message not found in $logFile"
	exit 1
fi

// ==== tbMipsExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsExec import mipsExecPkg::*; ();

	// Model outcome of one instruction
	typedef struct packed {
		word_t result;
		logic ovf;
		logic ill;
		logic wr;
		regIdx_t dst;
	} expect_t;

	localparam int ackTimeout = 40;

	localparam logic [5:0] arithFuncts [0:9] = '{functAdd, functAddu, functSub, functSubu,
		functAnd, functOr, functXor, functNor, functSlt, functSltu};
	localparam logic [5:0] shiftFuncts [0:5] = '{functSll, functSrl, functSra,
		functSllv, functSrlv, functSrav};

	logic clk;
	logic arstN;
	logic instrReq;
	word_t instrIn;
	logic instrAck;
	word_t resultOut;
	logic resultOverflow;
	logic resultIllegal;

	// Architectural state as the model sees it
	word_t shadow [0:31];
	expect_t pending [$];
	logic ackSeen;
	logic [31:0] lfsrState;

	mipsExecTop mipsExecTop_inst (
		.clk (clk),
		.arstN (arstN),
		.instrReq (instrReq),
		.instrIn (instrIn),
		.instrAck (instrAck),
		.resultOut (resultOut),
		.resultOverflow (resultOverflow),
		.resultIllegal (resultIllegal)
	);

	// 20 ns period
	always #10 clk = ~clk;

	////////////////////
	// Failure handling
	////////////////////
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input word_t got, input word_t expected);
		if (got !== expected)
		begin
			abortRun($sformatf("Error: %s got 0x%08h, expected 0x%08h", name, got, expected));
		end
	endtask

	////////////////////
	// Random source
	////////////////////
	// Galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
		begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return outBit;
	endfunction

	// One step per bit taken
	function automatic word_t randBits(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], stepLfsr()};
		end
		return r;
	endfunction

	////////////////////
	// Encoders
	////////////////////
	function automatic word_t encodeR(input logic [5:0] funct, input regIdx_t rs,
		input regIdx_t rt, input regIdx_t rd, input logic [4:0] shamt);
		return {opcodeSpecial, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t encodeI(input logic [5:0] opcode, input regIdx_t rs,
		input regIdx_t rt, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	////////////////////
	// Reference model
	////////////////////
	function automatic expect_t modelExec(input word_t instr);
		expect_t e;
		logic [5:0] opc;
		logic [5:0] fn;
		logic [4:0] sh;
		logic [15:0] imm;
		word_t a;
		word_t b;
		logic [32:0] wide;
		opc = instr[31:26];
		fn = instr[5:0];
		sh = instr[10:6];
		imm = instr[15:0];
		a = shadow[instr[25:21]];
		b = shadow[instr[20:16]];
		e.result = '0;
		e.ovf = 1'b0;
		e.ill = 1'b0;
		e.dst = instr[15:11];
		if (opc == opcodeSpecial)
		begin
			case (fn)
				functAdd:
				begin
					// Overflow when the 33-bit sum's top two bits disagree
					wide = {a[31], a} + {b[31], b};
					e.result = wide[31:0];
					e.ovf = wide[32] ^ wide[31];
				end
				functSub:
				begin
					wide = {a[31], a} - {b[31], b};
					e.result = wide[31:0];
					e.ovf = wide[32] ^ wide[31];
				end
				functAddu: e.result = a + b;
				functSubu: e.result = a - b;
				functAnd: e.result = a & b;
				functOr: e.result = a | b;
				functXor: e.result = a ^ b;
				functNor: e.result = ~(a | b);
				functSlt: e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				functSltu: e.result = (a < b) ? 32'd1 : 32'd0;
				functSll: e.result = b << sh;
				functSrl: e.result = b >> sh;
				functSra: e.result = $signed(b) >>> sh;
				// rs low five bits as amount
				functSllv: e.result = b << a[4:0];
				functSrlv: e.result = b >> a[4:0];
				functSrav: e.result = $signed(b) >>> a[4:0];
				default: e.ill = 1'b1;
			endcase
		end
		else
		begin
			// Immediate forms target rt
			e.dst = instr[20:16];
			case (opc)
				opcodeAddiu: e.result = a + {{16{imm[15]}}, imm};
				opcodeOri: e.result = a | {16'h0000, imm};
				opcodeLui: e.result = {imm, 16'h0000};
				default: e.ill = 1'b1;
			endcase
		end
		e.wr = !e.ill && !e.ovf && (e.dst != 5'd0);
		return e;
	endfunction

	////////////////////
	// Handshake helpers
	////////////////////
	task automatic waitAck(input logic level, input string what, output int waited);
		waited = 1;
		@(negedge clk);
		while (instrAck !== level)
		begin
			if (waited >= ackTimeout)
			begin
				abortRun($sformatf("timed out waiting for instrAck to %s", what));
			end
			waited++;
			@(negedge clk);
		end
	endtask

	// Full four-phase transfer, req optionally held past ack
	task automatic runInstr(input word_t instr, input int holdCycles);
		expect_t e;
		int waited;
		e = modelExec(instr);
		pending.push_back(e);
		if (e.wr)
		begin
			shadow[e.dst] = e.result;
		end
		@(posedge clk);
		instrReq <= 1'b1;
		instrIn <= instr;
		waitAck(1'b1, "rise", waited);
		// Two edges after the sampling edge
		checkValue("ackLatency", 32'(waited), 32'd3);
		for (int i = 0; i < holdCycles; i++)
		begin
			@(negedge clk);
			checkValue("instrAck", 32'(instrAck), 32'd1);
		end
		@(posedge clk);
		instrReq <= 1'b0;
		waitAck(1'b0, "fall", waited);
	endtask

	task automatic loadReg(input regIdx_t idx, input word_t value);
		runInstr(encodeI(opcodeLui, 5'd0, idx, value[31:16]), 0);
		runInstr(encodeI(opcodeOri, idx, idx, value[15:0]), 0);
	endtask

	////////////////////
	// Response checker
	////////////////////
	// One pop per rising ack
	always @(negedge clk)
	begin
		expect_t e;
		if (arstN && instrAck && !ackSeen)
		begin
			if (pending.size() == 0)
			begin
				abortRun("instrAck rose with no instruction outstanding");
			end
			else
			begin
				e = pending.pop_front();
				checkValue("resultOut", resultOut, e.result);
				checkValue("resultOverflow", 32'(resultOverflow), 32'(e.ovf));
				checkValue("resultIllegal", 32'(resultIllegal), 32'(e.ill));
			end
		end
		ackSeen = instrAck;
	end

	////////////////////
	// Stimulus
	////////////////////
	initial
	begin
		logic [3:0] pick;
		logic [2:0] shiftPick;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
		clk = 1'b0;
		arstN = 1'b0;
		instrReq = 1'b0;
		instrIn = '0;
		ackSeen = 1'b0;
		lfsrState = 32'h9e3b_ad3c;
		shadow = '{default: '0};

		repeat (16) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);

		// Idle outputs after reset
		checkValue("instrAck", 32'(instrAck), 32'd0);
		checkValue("resultOverflow", 32'(resultOverflow), 32'd0);
		checkValue("resultIllegal", 32'(resultIllegal), 32'd0);
		checkValue("resultOut", resultOut, 32'd0);
		runInstr(encodeR(functAddu, 5'd1, 5'd2, 5'd3, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'd0);

		// Constant built from LUI and ORI
		loadReg(5'd5, 32'h1234_5678);
		runInstr(encodeR(functAddu, 5'd5, 5'd0, 5'd6, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'h1234_5678);

		// Fill the file with random words
		for (int r = 1; r < 32; r++)
		begin
			loadReg(regIdx_t'(r), randBits(32));
		end

		// Random arithmetic, logic and ADDIU
		for (int k = 0; k < 150; k++)
		begin
			pick = 4'(randBits(8) % 11);
			rs = regIdx_t'(randBits(5));
			rt = regIdx_t'(randBits(5));
			rd = regIdx_t'(randBits(5));
			if (pick == 4'd10)
			begin
				runInstr(encodeI(opcodeAddiu, rs, rd, 16'(randBits(16))), 0);
			end
			else
			begin
				runInstr(encodeR(arithFuncts[pick], rs, rt, rd, 5'd0), 0);
			end
		end

		// Compares across the sign boundary
		loadReg(5'd7, 32'h8000_0001);
		loadReg(5'd8, 32'h7fff_ffff);
		runInstr(encodeR(functSlt, 5'd7, 5'd8, 5'd13, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'd1);
		runInstr(encodeR(functSltu, 5'd7, 5'd8, 5'd13, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'd0);
		runInstr(encodeR(functSlt, 5'd8, 5'd7, 5'd13, 5'd0), 0);
		runInstr(encodeR(functSltu, 5'd8, 5'd7, 5'd13, 5'd0), 0);

		// Fixed and variable shifts
		runInstr(encodeR(functSra, 5'd0, 5'd7, 5'd14, 5'd4), 0);
		checkValue("resultOut", resultOut, 32'hf800_0000);
		for (int k = 0; k < 80; k++)
		begin
			shiftPick = 3'(randBits(8) % 6);
			rs = regIdx_t'(randBits(5));
			rt = regIdx_t'(randBits(5));
			rd = regIdx_t'(randBits(5));
			runInstr(encodeR(shiftFuncts[shiftPick], rs, rt, rd, 5'(randBits(5))), 0);
		end

		// Overflowing ADD and SUB keep the destination
		loadReg(5'd7, 32'h8000_0001);
		loadReg(5'd9, 32'h7fff_ffff);
		loadReg(5'd10, 32'h0000_0001);
		loadReg(5'd11, 32'h1357_9bdf);
		runInstr(encodeR(functAdd, 5'd9, 5'd10, 5'd11, 5'd0), 0);
		checkValue("resultOverflow", 32'(resultOverflow), 32'd1);
		runInstr(encodeR(functAddu, 5'd11, 5'd0, 5'd12, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'h1357_9bdf);
		runInstr(encodeR(functSub, 5'd7, 5'd9, 5'd11, 5'd0), 0);
		checkValue("resultOverflow", 32'(resultOverflow), 32'd1);
		runInstr(encodeR(functAddu, 5'd11, 5'd0, 5'd12, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'h1357_9bdf);

		// Register zero ignores writes
		runInstr(encodeR(functAddu, 5'd9, 5'd10, 5'd0, 5'd0), 0);
		runInstr(encodeR(functAddu, 5'd0, 5'd0, 5'd12, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'd0);

		// Unknown funct, then unknown opcode
		runInstr(encodeR(6'b111111, 5'd9, 5'd10, 5'd11, 5'd0), 0);
		checkValue("resultIllegal", 32'(resultIllegal), 32'd1);
		runInstr(encodeI(6'b111111, 5'd9, 5'd11, 16'hffff), 0);
		checkValue("resultIllegal", 32'(resultIllegal), 32'd1);
		runInstr(encodeR(functAddu, 5'd11, 5'd0, 5'd12, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'h1357_9bdf);

		// Back-pressure, req held well past ack
		runInstr(encodeR(functAddu, 5'd9, 5'd10, 5'd14, 5'd0), 6);
		runInstr(encodeR(functOr, 5'd14, 5'd0, 5'd15, 5'd0), 0);
		checkValue("resultOut", resultOut, 32'h8000_0000);

		if (pending.size() != 0)
		begin
			abortRun("responses still outstanding at end of test");
		end
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
